// ==== src/hazard_settings.svh ====
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Field widths of the hazard subsystem
////////////////////////////////////////////////////////////

// Register index, rs/rt/rd fields
`define HAZARD_REG_W 5

// Full instruction word
`define HAZARD_INSTR_W 32

// Tnew and Tuse counters, values 0..2
`define HAZARD_T_W 2

// Link register written by jal
`define HAZARD_LINK_REG 31

`endif

// ==== src/hazard_pkg.sv ====
`include "hazard_settings.svh"

package hazard_pkg;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opR    = 6'b000000,
		opJ    = 6'b000010,
		opJal  = 6'b000011,
		opBeq  = 6'b000100,
		opAddi = 6'b001000,
		opAndi = 6'b001100,
		opOri  = 6'b001101,
		opLui  = 6'b001111,
		opLb   = 6'b100000,
		opLh   = 6'b100001,
		opLw   = 6'b100011,
		opSb   = 6'b101000,
		opSh   = 6'b101001,
		opSw   = 6'b101011,
		opLwId = 6'b110011
	} opcodeT;

	// R-type function, instr[5:0]
	typedef enum logic [5:0] {
		fnJr    = 6'b001000,
		fnMfhi  = 6'b010000,
		fnMthi  = 6'b010001,
		fnMflo  = 6'b010010,
		fnMtlo  = 6'b010011,
		fnMult  = 6'b011000,
		fnMultu = 6'b011001,
		fnDiv   = 6'b011010,
		fnDivu  = 6'b011011,
		fnAdd   = 6'b100000,
		fnSub   = 6'b100010,
		fnAnd   = 6'b100100,
		fnOr    = 6'b100101,
		fnSlt   = 6'b101010,
		fnSltu  = 6'b101011
	} functT;

	////////////////////////////////////////////////////////////
	// Hazard bookkeeping
	////////////////////////////////////////////////////////////

	// Where a decode operand is taken from
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdE    = 2'd1,
		fwdM    = 2'd2,
		fwdW    = 2'd3
	} fwdSelT;

	// Destination plus cycles until the value exists
	typedef struct packed {
		logic [`HAZARD_REG_W-1:0] dest;
		logic [`HAZARD_T_W-1:0]   tnew;
	} resultInfoT;

endpackage

// ==== src/tuseDecode.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module tuseDecode
	import hazard_pkg::*;
(
	input  logic [`HAZARD_INSTR_W-1:0] instrD,
	output logic [`HAZARD_REG_W-1:0]   rsD,
	output logic [`HAZARD_REG_W-1:0]   rtD,
	output logic [`HAZARD_T_W-1:0]     tuseRs,
	output logic [`HAZARD_T_W-1:0]     tuseRt,
	output logic                       useRs,
	output logic                       useRt
);

	opcodeT opcode;
	functT  funct;

	// Source fields are always at the same place
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];

	assign opcode = opcodeT'(instrD[31:26]);
	assign funct  = functT'(instrD[5:0]);

	always_comb begin
		// Default is no source read
		useRs  = 1'b0;
		useRt  = 1'b0;
		tuseRs = '0;
		tuseRt = '0;
		case (opcode)
			opR: begin
				case (funct)
					fnJr: begin
						useRs  = 1'b1;
						tuseRs = `HAZARD_T_W'(0);
					end
					fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
					fnMult, fnMultu, fnDiv, fnDivu, fnMthi, fnMtlo: begin
						useRs  = 1'b1;
						useRt  = 1'b1;
						tuseRs = `HAZARD_T_W'(1);
						tuseRt = `HAZARD_T_W'(1);
					end
					// mfhi, mflo and unknown functs read no GPR
					default: ;
				endcase
			end
			opOri, opAddi, opAndi, opLw, opLb, opLh, opLwId: begin
				useRs  = 1'b1;
				tuseRs = `HAZARD_T_W'(1);
			end
			opSw, opSb, opSh: begin
				// Address in E, store data only needed in M
				useRs  = 1'b1;
				useRt  = 1'b1;
				tuseRs = `HAZARD_T_W'(1);
				tuseRt = `HAZARD_T_W'(2);
			end
			opBeq: begin
				// Compared in decode
				useRs  = 1'b1;
				useRt  = 1'b1;
				tuseRs = `HAZARD_T_W'(0);
				tuseRt = `HAZARD_T_W'(0);
			end
			// lui, j, jal and unknown opcodes
			default: ;
		endcase
	end

endmodule

// ==== src/tnewDecode.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module tnewDecode
	import hazard_pkg::*;
(
	input  logic [`HAZARD_INSTR_W-1:0] instr,
	output resultInfoT                 res
);

	logic [`HAZARD_REG_W-1:0] rt;
	logic [`HAZARD_REG_W-1:0] rd;
	opcodeT opcode;
	functT  funct;

	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);

	////////////////////////////////////////////////////////////
	// Tnew and destination as seen from the execute stage
	////////////////////////////////////////////////////////////

	always_comb begin
		// Non-writers and unknown encodings never hazard
		res.dest = '0;
		res.tnew = '0;
		case (opcode)
			opR: begin
				case (funct)
					fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu: begin
						res.dest = rd;
						res.tnew = `HAZARD_T_W'(1);
					end
					fnMfhi, fnMflo: begin
						// HI/LO read happens in E like an ALU op
						res.dest = rd;
						res.tnew = `HAZARD_T_W'(1);
					end
					// jr, mult/div and mthi/mtlo write no GPR
					default: ;
				endcase
			end

			opOri, opAddi, opAndi, opLui: begin
				res.dest = rt;
				res.tnew = `HAZARD_T_W'(1);
			end

			opLw, opLb, opLh, opLwId: begin
				// Data returns at the end of M
				res.dest = rt;
				res.tnew = `HAZARD_T_W'(2);
			end

			opJal: begin
				// Link value is PC+8, known already in decode
				res.dest = `HAZARD_REG_W'(`HAZARD_LINK_REG);
				res.tnew = `HAZARD_T_W'(0);
			end

			// Stores, beq, j
			default: ;
		endcase
	end

endmodule

// ==== src/stageTrack.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

// Result info of the three in-flight stages
interface pipeTrackIf
	import hazard_pkg::*;
;
	resultInfoT resE;
	resultInfoT resM;
	resultInfoT resW;
	logic       validE;
	logic       validM;
	logic       validW;

	modport trackSide (output resE, resM, resW, validE, validM, validW);
	modport hazardSide (input resE, resM, resW, validE, validM, validW);
endinterface

module stageTrack
	import hazard_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       stall,
	input  resultInfoT resD,
	pipeTrackIf.trackSide trk
);

	////////////////////////////////////////////////////////////
	// Valid bits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			trk.validE <= 1'b0;
			trk.validM <= 1'b0;
			trk.validW <= 1'b0;
		end else begin
			// Bubble into E while decode is held
			trk.validE <= !stall;
			trk.validM <= trk.validE;
			trk.validW <= trk.validM;
		end
	end

	////////////////////////////////////////////////////////////
	// Result payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		trk.resE <= stall ? '0 : resD;

		// One stage closer, saturating at zero
		trk.resM.dest <= trk.resE.dest;
		trk.resM.tnew <= (trk.resE.tnew == '0) ? '0 : trk.resE.tnew - 1'b1;

		// Everything in W is ready
		trk.resW.dest <= trk.resM.dest;
		trk.resW.tnew <= '0;
	end

endmodule

// ==== src/stallForward.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module stallForward
	import hazard_pkg::*;
(
	input  logic [`HAZARD_REG_W-1:0] rsD,
	input  logic [`HAZARD_REG_W-1:0] rtD,
	input  logic [`HAZARD_T_W-1:0]   tuseRs,
	input  logic [`HAZARD_T_W-1:0]   tuseRt,
	input  logic                     useRs,
	input  logic                     useRt,
	pipeTrackIf.hazardSide           trk,
	output logic                     stall,
	output fwdSelT                   fwdRsSel,
	output fwdSelT                   fwdRtSel
);

	// Producer ahead would not have its value in time
	function automatic logic needStall(
		input logic [`HAZARD_REG_W-1:0] src,
		input logic                     used,
		input logic [`HAZARD_T_W-1:0]   tuse
	);
		logic hitE;
		logic hitM;
		hitE = trk.validE && (trk.resE.dest == src) && (trk.resE.tnew > tuse);
		hitM = trk.validM && (trk.resM.dest == src) && (trk.resM.tnew > tuse);
		return used && (src != '0) && (hitE || hitM);
	endfunction

	// Youngest ready producer wins
	function automatic fwdSelT pickFwd(input logic [`HAZARD_REG_W-1:0] src);
		fwdSelT sel;
		sel = fwdNone;
		if (src != '0) begin
			if (trk.validE && (trk.resE.dest == src) && (trk.resE.tnew == '0))
				sel = fwdE;
			else if (trk.validM && (trk.resM.dest == src) && (trk.resM.tnew == '0))
				sel = fwdM;
			else if (trk.validW && (trk.resW.dest == src))
				sel = fwdW;
		end
		return sel;
	endfunction

	assign stall = needStall(rsD, useRs, tuseRs) || needStall(rtD, useRt, tuseRt);

	assign fwdRsSel = pickFwd(rsD);
	assign fwdRtSel = pickFwd(rtD);

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit
	import hazard_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`HAZARD_INSTR_W-1:0] instrD,
	output logic                       stall,
	output logic [1:0]                 fwdRsSel,
	output logic [1:0]                 fwdRtSel
);

	resultInfoT               resD;
	logic [`HAZARD_REG_W-1:0] rsD;
	logic [`HAZARD_REG_W-1:0] rtD;
	logic [`HAZARD_T_W-1:0]   tuseRs;
	logic [`HAZARD_T_W-1:0]   tuseRt;
	logic                     useRs;
	logic                     useRt;

	pipeTrackIf trk ();

	////////////////////////////////////////////////////////////
	// Decode side
	////////////////////////////////////////////////////////////

	tuseDecode tuseDecode_i (
		.instrD (instrD),
		.rsD    (rsD),
		.rtD    (rtD),
		.tuseRs (tuseRs),
		.tuseRt (tuseRt),
		.useRs  (useRs),
		.useRt  (useRt)
	);

	// Info the instruction carries once it enters E
	tnewDecode tnewDecode_i (
		.instr (instrD),
		.res   (resD)
	);

	////////////////////////////////////////////////////////////
	// In-flight stages and hazard decision
	////////////////////////////////////////////////////////////

	stageTrack stageTrack_i (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.resD  (resD),
		.trk   (trk.trackSide)
	);

	stallForward stallForward_i (
		.rsD      (rsD),
		.rtD      (rtD),
		.tuseRs   (tuseRs),
		.tuseRt   (tuseRt),
		.useRs    (useRs),
		.useRt    (useRt),
		.trk      (trk.hazardSide),
		.stall    (stall),
		.fwdRsSel (fwdRsSel),
		.fwdRtSel (fwdRtSel)
	);

endmodule

// ==== sim/hazardUnit_assert.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit_assert
	import hazard_pkg::*;
(
	input logic                       clk,
	input logic                       reset,
	input logic [`HAZARD_INSTR_W-1:0] instrD,
	input logic                       stall,
	input logic [1:0]                 fwdRsSel,
	input logic [1:0]                 fwdRtSel
);

	// Read by the testbench after each test
	int failCount = 0;

	logic [`HAZARD_REG_W-1:0] destE, destM, destW;
	logic [`HAZARD_T_W-1:0]   tnewE, tnewM;
	logic                     validE, validM, validW;
	logic                     expStall;
	logic [1:0]               expRs, expRt;
	resultInfoT               entering;

	////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////

	// Destination and Tnew once the instruction sits in E
	function automatic resultInfoT writes(input logic [`HAZARD_INSTR_W-1:0] ins);
		resultInfoT r;
		opcodeT     op;
		functT      fn;
		op = opcodeT'(ins[31:26]);
		fn = functT'(ins[5:0]);
		r = '0;
		if (op == opR && fn inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
				fnMfhi, fnMflo}) begin
			r.dest = ins[15:11];
			r.tnew = 2'd1;
		end else if (op inside {opOri, opAddi, opAndi, opLui}) begin
			r.dest = ins[20:16];
			r.tnew = 2'd1;
		end else if (op inside {opLw, opLb, opLh, opLwId}) begin
			r.dest = ins[20:16];
			r.tnew = 2'd2;
		end else if (op == opJal) begin
			r.dest = 5'd31;
		end
		return r;
	endfunction

	// {used, Tuse} of rs or of rt
	function automatic logic [2:0] reads(input logic [`HAZARD_INSTR_W-1:0] ins,
			input logic isRt);
		opcodeT op;
		functT  fn;
		op = opcodeT'(ins[31:26]);
		fn = functT'(ins[5:0]);
		if (op == opBeq)
			return 3'b100;
		if (op == opR && fn == fnJr)
			return isRt ? 3'b000 : 3'b100;
		if (op == opR && fn inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu, fnMult,
				fnMultu, fnDiv, fnDivu, fnMthi, fnMtlo})
			return 3'b101;
		if (op inside {opOri, opAddi, opAndi, opLw, opLb, opLh, opLwId})
			return isRt ? 3'b000 : 3'b101;
		if (op inside {opSw, opSb, opSh})
			return isRt ? 3'b110 : 3'b101;
		return 3'b000;
	endfunction

	function automatic logic srcStall(input logic [4:0] src, input logic [2:0] use3);
		if (!use3[2] || src == '0)
			return 1'b0;
		return (validE && destE == src && tnewE > use3[1:0])
			|| (validM && destM == src && tnewM > use3[1:0]);
	endfunction

	// E before M before W
	function automatic logic [1:0] srcFwd(input logic [4:0] src);
		if (src == '0)
			return fwdNone;
		if (validE && destE == src && tnewE == '0)
			return fwdE;
		if (validM && destM == src && tnewM == '0)
			return fwdM;
		if (validW && destW == src)
			return fwdW;
		return fwdNone;
	endfunction

	always_comb begin
		expStall = srcStall(instrD[25:21], reads(instrD, 1'b0))
			|| srcStall(instrD[20:16], reads(instrD, 1'b1));
		expRs    = srcFwd(instrD[25:21]);
		expRt    = srcFwd(instrD[20:16]);
		entering = writes(instrD);
	end

	////////////////////////////////////////////////////////////
	// Shadow pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			validE <= 1'b0;
			validM <= 1'b0;
			validW <= 1'b0;
		end else begin
			validE <= !stall;
			validM <= validE;
			validW <= validM;
		end
		destE <= stall ? '0 : entering.dest;
		tnewE <= stall ? '0 : entering.tnew;
		destM <= destE;
		tnewM <= (tnewE == '0) ? '0 : tnewE - 2'd1;
		destW <= destM;
	end

	idleOutputs: assert property (@(posedge clk) disable iff (reset)
		!(validE || validM || validW) |->
			(!stall && fwdRsSel == fwdNone && fwdRtSel == fwdNone))
		else begin
			failCount++;
			$error("stall or forward active with an empty pipeline");
		end

	stallRule: assert property (@(posedge clk) disable iff (reset) stall == expStall)
		else begin
			failCount++;
			$error("stall differs from the Tuse/Tnew rule");
		end

	rsForward: assert property (@(posedge clk) disable iff (reset) fwdRsSel == expRs)
		else begin
			failCount++;
			$error("rs forward select differs from the priority rule");
		end

	rtForward: assert property (@(posedge clk) disable iff (reset) fwdRtSel == expRt)
		else begin
			failCount++;
			$error("rt forward select differs from the priority rule");
		end

endmodule

bind hazardUnit hazardUnit_assert hazardAssert_i (
	.clk      (clk),
	.reset    (reset),
	.instrD   (instrD),
	.stall    (stall),
	.fwdRsSel (fwdRsSel),
	.fwdRtSel (fwdRtSel)
);

// ==== sim/hazardUnit_tb.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit_tb
	import hazard_pkg::*;
;

	localparam int stallLimit = 8;

	logic                       clk;
	logic                       reset;
	logic [`HAZARD_INSTR_W-1:0] instrD;
	logic                       stall;
	logic [1:0]                 fwdRsSel;
	logic [1:0]                 fwdRtSel;
	logic [31:0]                lfsr;
	logic                       hung;
	int                         testsPassed;
	int                         testsFailed;
	int                         failsBefore;

	hazardUnit hazardUnit_i (
		.clk      (clk),
		.reset    (reset),
		.instrD   (instrD),
		.stall    (stall),
		.fwdRsSel (fwdRsSel),
		.fwdRtSel (fwdRtSel)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Encoders and random source
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rType(input functT fn, input logic [4:0] rs, rt, rd);
		return {opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs, rt);
		return {op, rs, rt, 16'h0004};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Registers r0..r7 only, so producers and readers collide often
	// jr returns through r31 so it meets the jal links
	task automatic randInstr(output logic [31:0] ins);
		logic [31:0] k, a, b, c;
		takeBits(4, k);
		takeBits(3, a);
		takeBits(3, b);
		takeBits(3, c);
		case (k[3:0])
			4'd0: ins = rType(fnAdd, a[4:0], b[4:0], c[4:0]);
			4'd1: ins = rType(fnSlt, a[4:0], b[4:0], c[4:0]);
			4'd2: ins = iType(opOri, a[4:0], b[4:0]);
			4'd3: ins = iType(opAddi, a[4:0], b[4:0]);
			4'd4: ins = iType(opLui, 5'd0, b[4:0]);
			4'd5: ins = iType(opLw, a[4:0], b[4:0]);
			4'd6: ins = iType(opLh, a[4:0], b[4:0]);
			4'd7: ins = iType(opSw, a[4:0], b[4:0]);
			4'd8: ins = iType(opBeq, a[4:0], b[4:0]);
			4'd9: ins = rType(fnJr, 5'd31, 5'd0, 5'd0);
			4'd10: ins = iType(opJal, a[4:0], b[4:0]);
			4'd11: ins = rType(fnMult, a[4:0], b[4:0], 5'd0);
			4'd12: ins = rType(fnMfhi, 5'd0, 5'd0, c[4:0]);
			4'd13: ins = iType(opLwId, a[4:0], b[4:0]);
			4'd14: ins = iType(opSb, a[4:0], b[4:0]);
			default: ins = iType(opJ, a[4:0], b[4:0]);
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Hold the instruction in decode until stall drops
	task automatic issue(input logic [31:0] ins);
		int waited;
		waited = 0;
		if (!hung) begin
			@(negedge clk);
			instrD = ins;
			#1;
			while (stall && !hung) begin
				if (waited == stallLimit) begin
					$display("timeout: stall stayed high for %0d cycles", stallLimit);
					hung = 1'b1;
				end else begin
					@(negedge clk);
					#1;
					waited++;
				end
			end
		end
	endtask

	task automatic finishTest(input string name);
		int fails;
		repeat (3) issue('0);
		fails = hazardUnit_i.hazardAssert_i.failCount - failsBefore;
		failsBefore = hazardUnit_i.hazardAssert_i.failCount;
		if (fails == 0) begin
			$display("test %s done, no assertion failures", name);
			testsPassed++;
		end else begin
			$display("CHECK FAILED test %s: expected 0 assertion failures, actual %0d",
				name, fails);
			testsFailed++;
		end
	endtask

	initial begin
		logic [31:0] ins;
		clk = 1'b0;
		reset = 1'b1;
		// Load into r5 reaches E while reset is high
		instrD = iType(opLw, 5'd1, 5'd5);
		lfsr = 32'h9587453e;
		hung = 1'b0;
		testsPassed = 0;
		testsFailed = 0;
		failsBefore = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Would stall if reset left that load valid
		instrD = rType(fnAdd, 5'd5, 5'd2, 5'd6);

		finishTest("reset");

		issue(iType(opLw, 5'd1, 5'd5));
		issue(rType(fnAdd, 5'd5, 5'd2, 5'd6));
		finishTest("loadUse");

		issue(iType(opAddi, 5'd1, 5'd7));
		issue(iType(opBeq, 5'd7, 5'd0));
		issue(rType(fnAdd, 5'd1, 5'd2, 5'd8));
		issue(iType(opSw, 5'd3, 5'd8));
		finishTest("aluBranchStore");

		// Second link sits in E while the first is in M
		issue(iType(opJal, 5'd0, 5'd0));
		issue(iType(opJal, 5'd0, 5'd0));
		issue(rType(fnJr, 5'd31, 5'd0, 5'd0));
		finishTest("jalJr");

		// Nothing here writes a register the readers use
		issue(iType(opSw, 5'd4, 5'd4));
		issue(iType(opJ, 5'd4, 5'd4));
		issue(rType(fnMult, 5'd4, 5'd4, 5'd0));
		issue(rType(fnMthi, 5'd4, 5'd0, 5'd0));
		issue(iType(opLw, 5'd1, 5'd0));
		issue(rType(fnAdd, 5'd4, 5'd0, 5'd9));
		finishTest("nonWriters");

		for (int n = 0; n < 200; n++) begin
			randInstr(ins);
			issue(ins);
		end
		finishTest("random");

		$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (hung || testsFailed != 0) begin
			$display("TEST RESULT: FAIL");
		end else begin
			$display("TEST RESULT: PASS");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+src
src/hazard_pkg.sv
src/tuseDecode.sv
src/tnewDecode.sv
src/stageTrack.sv
src/stallForward.sv
src/hazardUnit.sv
sim/hazardUnit_assert.sv
sim/hazardUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module hazardUnit_tb -f project.f -o hazardUnit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Let assertion errors accumulate so the testbench reaches its summary
./obj_dir/hazardUnit_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
